//--- verilog.f
+incdir+include
design/core_types_pkg.sv
design/div_rs_pkg.sv
design/rs_dispatch_alloc.sv
design/rs_entry.sv
design/rs_issue_select.sv
design/rs_div_top.sv
test/rs_div_tb.sv

//--- include/rs_div_ref.svh
`ifndef RS_DIV_REF_SVH
`define RS_DIV_REF_SVH

localparam int ref_entries = 16;
localparam int ref_wake    = 7;

typedef struct {
  bit                    busy;
  bit                    rdy1;
  bit                    rdy2;
  core_types_pkg::pc_t   pc;
  core_types_pkg::tag_t  rd;
  div_rs_pkg::div_op_e   op;
  core_types_pkg::tag_t  src1;
  core_types_pkg::tag_t  src2;
} ref_entry_t;

ref_entry_t ref_model [ref_entries];

// Lowest free slot or -1 when the station is full
function automatic int lowest_free();
  for (int i = 0; i < ref_entries; i++) begin
    if (!ref_model[i].busy) return i;
  end
  return -1;
endfunction

// Wakes stored operands and resolves the dispatch rdy bits against the same ports
function automatic void apply_wakeups(input logic wv [ref_wake],
                                      input core_types_pkg::tag_t wt [ref_wake],
                                      input core_types_pkg::tag_t disp_src1,
                                      input core_types_pkg::tag_t disp_src2,
                                      inout bit disp_rdy1,
                                      inout bit disp_rdy2);
  for (int w = 0; w < ref_wake; w++) begin
    if (wv[w]) begin
      foreach (ref_model[i]) begin
        if (ref_model[i].busy && ref_model[i].src1 == wt[w]) ref_model[i].rdy1 = 1'b1;
        if (ref_model[i].busy && ref_model[i].src2 == wt[w]) ref_model[i].rdy2 = 1'b1;
      end
      if (wt[w] == disp_src1) disp_rdy1 = 1'b1;
      if (wt[w] == disp_src2) disp_rdy2 = 1'b1;
    end
  end
endfunction

// Entry that issues at the next edge or -1 when none is ready
function automatic int next_issue(output ref_entry_t e);
  e = ref_model[0];
  for (int i = 0; i < ref_entries; i++) begin
    if (ref_model[i].busy && ref_model[i].rdy1 && ref_model[i].rdy2) begin
      e = ref_model[i];
      return i;
    end
  end
  return -1;
endfunction

`endif

//--- test/rs_div_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rs_div_tb;

  import core_types_pkg::*;
  import div_rs_pkg::*;

`include "rs_div_ref.svh"

  localparam real clk_period   = 4.0;
  localparam int  len_directed = 200;  // Tests 1 to 4 in cycles
  localparam int  len_random   = 2000;
  localparam int  margin       = 100;

  logic    clk;
  logic    reset;
  logic    flush;
  logic    disp_valid;
  pc_t     disp_pc;
  tag_t    disp_rd, disp_src1, disp_src2;
  div_op_e disp_op;
  logic    disp_rdy1, disp_rdy2;
  logic    wake_valid [ref_wake];
  tag_t    wake_tag   [ref_wake];
  logic    rs_full;
  logic    issue_valid;
  pc_t     issue_pc;
  tag_t    issue_rd, issue_src1, issue_src2;
  div_op_e issue_op;

  string test_name      = "reset";
  int    mismatch_count = 0;
  int    other_count    = 0;

  rs_div_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatch_count++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // Strobes last one cycle
  task automatic tick();
    @(posedge clk);
    #0.5;
    disp_valid = 1'b0;
    flush      = 1'b0;
    foreach (wake_valid[w]) wake_valid[w] = 1'b0;
  endtask

  // rd and op come from the pc bits
  task automatic dispatch(input pc_t pc, input tag_t s1, input tag_t s2,
                          input logic r1, input logic r2);
    disp_valid = 1'b1;
    disp_pc    = pc;
    disp_rd    = pc[9:2];
    disp_op    = div_op_e'({pc[2], 1'b1, pc[1:0]});
    disp_src1  = s1;
    disp_src2  = s2;
    disp_rdy1  = r1;
    disp_rdy2  = r2;
  endtask

  task automatic broadcast(input int port, input tag_t tag);
    wake_valid[port] = 1'b1;
    wake_tag[port]   = tag;
  endtask

  task automatic await_issue(input pc_t exp_pc, input int max_cycles);
    int n;
    n = 0;
    tick();
    while (issue_valid !== 1'b1 && n < max_cycles) begin
      tick();
      n++;
    end
    assert (issue_valid === 1'b1) else begin
      other_count++;
      $display("%s: no issue arrived within %0d cycles", test_name, max_cycles);
    end
    if (issue_valid === 1'b1) check_value("issue_pc", exp_pc, issue_pc);
  endtask

  ////////////////////
  // Model and compare
  ////////////////////

  initial begin : compare
    ref_entry_t e;
    ref_entry_t exp_e;
    int         idx;
    int         fidx;
    bit         r1;
    bit         r2;
    bit         exp_valid;
    exp_valid = 1'b0;
    forever begin
      @(posedge clk);  // Inputs were driven half a ns after the previous edge
      if (reset || flush) begin
        foreach (ref_model[i]) begin
          ref_model[i].busy = 1'b0;
          ref_model[i].rdy1 = 1'b0;
          ref_model[i].rdy2 = 1'b0;
        end
        exp_valid = 1'b0;
      end else begin
        idx       = next_issue(e);
        exp_valid = (idx >= 0);
        exp_e     = e;
        fidx      = lowest_free();  // Slots freed at this edge are not yet free
        r1        = disp_rdy1;
        r2        = disp_rdy2;
        apply_wakeups(wake_valid, wake_tag, disp_src1, disp_src2, r1, r2);
        if (idx >= 0) begin
          ref_model[idx].busy = 1'b0;
          ref_model[idx].rdy1 = 1'b0;
          ref_model[idx].rdy2 = 1'b0;
        end
        if (disp_valid && fidx >= 0) begin
          ref_model[fidx].busy = 1'b1;
          ref_model[fidx].rdy1 = r1;
          ref_model[fidx].rdy2 = r2;
          ref_model[fidx].pc   = disp_pc;
          ref_model[fidx].rd   = disp_rd;
          ref_model[fidx].op   = disp_op;
          ref_model[fidx].src1 = disp_src1;
          ref_model[fidx].src2 = disp_src2;
        end
      end
      @(negedge clk);
      check_value("issue_valid", exp_valid, issue_valid);
      check_value("rs_full", lowest_free() < 0, rs_full);
      if (exp_valid) begin
        check_value("issue_pc", exp_e.pc, issue_pc);
        check_value("issue_rd", exp_e.rd, issue_rd);
        check_value("issue_op", exp_e.op, issue_op);
        check_value("issue_src1", exp_e.src1, issue_src1);
        check_value("issue_src2", exp_e.src2, issue_src2);
      end
    end
  end

  initial begin : watchdog
    #((len_directed + len_random + margin) * clk_period);
    $display("Watchdog expired in %s, the run did not finish in time", test_name);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    void'($urandom(32'h07a30708));
    reset = 1'b1;
    flush = 1'b0;
    dispatch('0, '0, '0, 1'b0, 1'b0);
    disp_valid = 1'b0;
    foreach (wake_valid[w]) begin
      wake_valid[w] = 1'b0;
      wake_tag[w]   = '0;
    end
    repeat (2) @(posedge clk);
    #0.5;
    reset = 1'b0;

    test_name = "basic";
    check_value("issue_valid", 0, issue_valid);
    check_value("rs_full", 0, rs_full);
    dispatch(32'h0000_1004, 8'h11, 8'h12, 1'b1, 1'b1);
    tick();
    check_value("issue_valid", 0, issue_valid);
    tick();
    check_value("issue_valid", 1, issue_valid);
    check_value("issue_pc", 32'h0000_1004, issue_pc);
    check_value("issue_rd", 8'h01, issue_rd);
    check_value("issue_op", op_divw, issue_op);
    check_value("issue_src1", 8'h11, issue_src1);
    check_value("issue_src2", 8'h12, issue_src2);

    test_name = "wake_ports";
    for (int p = 0; p < ref_wake; p++) begin
      dispatch(32'h2000 + 16 * p, tag_t'(8'h40 + p), tag_t'(8'h50 + p), 1'b0, 1'b0);
      tick();
      tick();
      broadcast(p, tag_t'(8'h40 + p));
      tick();
      broadcast(p, tag_t'(8'h50 + p));
      tick();
      check_value("issue_valid", 0, issue_valid);
      tick();
      check_value("issue_valid", 1, issue_valid);
      check_value("issue_pc", 32'h2000 + 16 * p, issue_pc);
      // Wakeup in the dispatch cycle
      dispatch(32'h2100 + 16 * p, tag_t'(8'h60 + p), tag_t'(8'h70 + p), 1'b1, 1'b0);
      broadcast(p, tag_t'(8'h70 + p));
      await_issue(32'h2100 + 16 * p, 4);
    end

    test_name = "fill_order";
    for (int i = 0; i < ref_entries; i++) begin
      dispatch(32'h3000 + 4 * i, 8'h90, 8'h91, 1'b0, 1'b1);
      tick();
    end
    check_value("rs_full", 1, rs_full);
    dispatch(32'h3f00, 8'h92, 8'h93, 1'b1, 1'b1);  // Dropped while full
    tick();
    broadcast(3, 8'h90);
    tick();
    for (int i = 0; i < ref_entries; i++) begin
      tick();
      check_value("issue_valid", 1, issue_valid);
      check_value("issue_pc", 32'h3000 + 4 * i, issue_pc);
    end
    tick();
    check_value("issue_valid", 0, issue_valid);

    test_name = "flush";
    dispatch(32'h4000, 8'hb0, 8'hb1, 1'b0, 1'b1);
    tick();
    dispatch(32'h4010, 8'hb2, 8'hb3, 1'b1, 1'b1);
    tick();
    flush = 1'b1;
    dispatch(32'h4020, 8'hb4, 8'hb5, 1'b1, 1'b1);  // Flush wins over dispatch
    tick();
    flush = 1'b1;
    broadcast(0, 8'hb0);
    repeat (5) begin
      tick();
      check_value("issue_valid", 0, issue_valid);
    end
    dispatch(32'h4800, 8'hb6, 8'hb7, 1'b1, 1'b1);
    await_issue(32'h4800, 4);

    test_name = "random";
    repeat (len_random) begin
      if (!rs_full && $urandom_range(9, 0) < 4) begin
        dispatch($urandom(), tag_t'($urandom_range(31, 0)), tag_t'($urandom_range(31, 0)),
                 $urandom_range(1, 0) == 0, $urandom_range(1, 0) == 0);
      end
      for (int w = 0; w < ref_wake; w++) begin
        if ($urandom_range(9, 0) < 3) broadcast(w, tag_t'($urandom_range(31, 0)));
      end
      flush = ($urandom_range(99, 0) == 0);
      tick();
    end
    repeat (3) tick();

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/rs_div_top.sv
`timescale 1ns/10ps
`default_nettype none

module rs_div_top #(
  parameter int num_entries = 16,
  parameter int num_wake    = 7
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,       // Exception or mret
  input  logic                  disp_valid,
  input  core_types_pkg::pc_t   disp_pc,
  input  core_types_pkg::tag_t  disp_rd,
  input  div_rs_pkg::div_op_e   disp_op,
  input  core_types_pkg::tag_t  disp_src1,
  input  core_types_pkg::tag_t  disp_src2,
  input  logic                  disp_rdy1,
  input  logic                  disp_rdy2,
  input  logic                  wake_valid [num_wake],
  input  core_types_pkg::tag_t  wake_tag   [num_wake],
  output logic                  rs_full,
  output logic                  issue_valid,
  output core_types_pkg::pc_t   issue_pc,
  output core_types_pkg::tag_t  issue_rd,
  output div_rs_pkg::div_op_e   issue_op,
  output core_types_pkg::tag_t  issue_src1,
  output core_types_pkg::tag_t  issue_src2
);

  import core_types_pkg::*;
  import div_rs_pkg::*;

  logic [num_entries-1:0] busy;
  logic [num_entries-1:0] ready;
  logic [num_entries-1:0] alloc_we;
  logic [num_entries-1:0] grant;
  logic                   alloc_rdy1;
  logic                   alloc_rdy2;

  // Stored fields of every entry
  pc_t     e_pc   [num_entries];
  tag_t    e_rd   [num_entries];
  div_op_e e_op   [num_entries];
  tag_t    e_src1 [num_entries];
  tag_t    e_src2 [num_entries];

  ////////////////////
  // Dispatch
  ////////////////////

  rs_dispatch_alloc #(
    .num_entries (num_entries),
    .num_wake    (num_wake)
  ) u_alloc (
    .disp_valid  (disp_valid),
    .disp_src1   (disp_src1),
    .disp_src2   (disp_src2),
    .disp_rdy1   (disp_rdy1),
    .disp_rdy2   (disp_rdy2),
    .busy        (busy),
    .wake_valid  (wake_valid),
    .wake_tag    (wake_tag),
    .alloc_we    (alloc_we),
    .alloc_rdy1  (alloc_rdy1),
    .alloc_rdy2  (alloc_rdy2),
    .rs_full     (rs_full)
  );

  ////////////////////
  // Entries
  ////////////////////

  for (genvar g = 0; g < num_entries; g++) begin : g_entry
    rs_entry #(
      .num_wake (num_wake)
    ) u_entry (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .we         (alloc_we[g]),
      .grant      (grant[g]),
      .pc_in      (disp_pc),   // Only the selected entry writes
      .rd_in      (disp_rd),
      .op_in      (disp_op),
      .src1_in    (disp_src1),
      .src2_in    (disp_src2),
      .rdy1_in    (alloc_rdy1),
      .rdy2_in    (alloc_rdy2),
      .wake_valid (wake_valid),
      .wake_tag   (wake_tag),
      .busy       (busy[g]),
      .ready      (ready[g]),
      .pc         (e_pc[g]),
      .rd         (e_rd[g]),
      .op         (e_op[g]),
      .src1       (e_src1[g]),
      .src2       (e_src2[g])
    );
  end

  ////////////////////
  // Issue
  ////////////////////

  rs_issue_select #(
    .num_entries (num_entries)
  ) u_select (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .ready       (ready),
    .entry_pc    (e_pc),
    .entry_rd    (e_rd),
    .entry_op    (e_op),
    .entry_src1  (e_src1),
    .entry_src2  (e_src2),
    .grant       (grant),
    .issue_valid (issue_valid),
    .issue_pc    (issue_pc),
    .issue_rd    (issue_rd),
    .issue_op    (issue_op),
    .issue_src1  (issue_src1),
    .issue_src2  (issue_src2)
  );

endmodule

`default_nettype wire

//--- design/rs_issue_select.sv
`timescale 1ns/10ps
`default_nettype none

module rs_issue_select #(
  parameter int num_entries = 16
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic [num_entries-1:0]  ready,
  input  core_types_pkg::pc_t     entry_pc   [num_entries],
  input  core_types_pkg::tag_t    entry_rd   [num_entries],
  input  div_rs_pkg::div_op_e     entry_op   [num_entries],
  input  core_types_pkg::tag_t    entry_src1 [num_entries],
  input  core_types_pkg::tag_t    entry_src2 [num_entries],
  output logic [num_entries-1:0]  grant,
  output logic                    issue_valid,
  output core_types_pkg::pc_t     issue_pc,
  output core_types_pkg::tag_t    issue_rd,
  output div_rs_pkg::div_op_e     issue_op,
  output core_types_pkg::tag_t    issue_src1,
  output core_types_pkg::tag_t    issue_src2
);

  import div_rs_pkg::*;

  localparam int idx_w = entry_idx_w(num_entries);

  logic [idx_w-1:0] sel_idx;
  logic             sel_found;

  ////////////////////
  // Ready priority
  ////////////////////

  // One pass from index 0 upward
  always_comb begin : ready_scan
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      if (ready[i] && !sel_found) begin
        sel_idx   = idx_w'(i);
        sel_found = 1'b1;
      end
    end
  end

  always_comb begin : grant_decode
    grant = '0;
    if (sel_found && !flush) begin
      grant[sel_idx] = 1'b1;  // Frees the entry at the issue edge
    end
  end

  ////////////////////
  // Issue registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= sel_found;  // One-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (sel_found) begin
      issue_pc   <= entry_pc[sel_idx];
      issue_rd   <= entry_rd[sel_idx];
      issue_op   <= entry_op[sel_idx];
      issue_src1 <= entry_src1[sel_idx];
      issue_src2 <= entry_src2[sel_idx];
    end
  end

endmodule

`default_nettype wire

//--- design/rs_entry.sv
`timescale 1ns/10ps
`default_nettype none

module rs_entry #(
  parameter int num_wake = 7
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    we,
  input  logic                    grant,
  input  core_types_pkg::pc_t     pc_in,
  input  core_types_pkg::tag_t    rd_in,
  input  div_rs_pkg::div_op_e     op_in,
  input  core_types_pkg::tag_t    src1_in,
  input  core_types_pkg::tag_t    src2_in,
  input  logic                    rdy1_in,
  input  logic                    rdy2_in,
  input  logic                    wake_valid [num_wake],
  input  core_types_pkg::tag_t    wake_tag   [num_wake],
  output logic                    busy,
  output logic                    ready,
  output core_types_pkg::pc_t     pc,
  output core_types_pkg::tag_t    rd,
  output div_rs_pkg::div_op_e     op,
  output core_types_pkg::tag_t    src1,
  output core_types_pkg::tag_t    src2
);

  logic rdy1;
  logic rdy2;
  logic wake1;
  logic wake2;

  ////////////////////
  // Wakeup snoop
  ////////////////////

  always_comb begin : snoop
    wake1 = 1'b0;
    wake2 = 1'b0;
    for (int w = 0; w < num_wake; w++) begin
      if (wake_valid[w] && (wake_tag[w] == src1)) begin
        wake1 = 1'b1;
      end
      if (wake_valid[w] && (wake_tag[w] == src2)) begin
        wake2 = 1'b1;
      end
    end
  end

  ////////////////////
  // Entry state
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      busy <= 1'b0;
      rdy1 <= 1'b0;
      rdy2 <= 1'b0;
    end else if (grant) begin  // Released as it issues
      busy <= 1'b0;
      rdy1 <= 1'b0;
      rdy2 <= 1'b0;
    end else if (we) begin
      busy <= 1'b1;
      rdy1 <= rdy1_in;  // Already resolved by the allocator
      rdy2 <= rdy2_in;
    end else if (busy) begin
      if (wake1) rdy1 <= 1'b1;
      if (wake2) rdy2 <= 1'b1;
    end
  end

  // Instruction fields
  always_ff @(posedge clk) begin
    if (we) begin
      pc   <= pc_in;
      rd   <= rd_in;
      op   <= op_in;
      src1 <= src1_in;
      src2 <= src2_in;
    end
  end

  assign ready = busy & rdy1 & rdy2;

endmodule

`default_nettype wire

//--- design/rs_dispatch_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module rs_dispatch_alloc #(
  parameter int num_entries = 16,
  parameter int num_wake    = 7
) (
  input  logic                     disp_valid,
  input  core_types_pkg::tag_t     disp_src1,
  input  core_types_pkg::tag_t     disp_src2,
  input  logic                     disp_rdy1,
  input  logic                     disp_rdy2,
  input  logic [num_entries-1:0]   busy,
  input  logic                     wake_valid [num_wake],
  input  core_types_pkg::tag_t     wake_tag   [num_wake],
  output logic [num_entries-1:0]   alloc_we,
  output logic                     alloc_rdy1,
  output logic                     alloc_rdy2,
  output logic                     rs_full
);

  import div_rs_pkg::*;

  localparam int idx_w = entry_idx_w(num_entries);

  logic [idx_w-1:0] free_idx;
  logic             free_found;
  logic             hit1;
  logic             hit2;

  ////////////////////
  // Free entry search
  ////////////////////

  always_comb begin : free_scan
    free_idx   = '0;
    free_found = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      if (!busy[i] && !free_found) begin  // Lowest index wins
        free_idx   = idx_w'(i);
        free_found = 1'b1;
      end
    end
  end

  always_comb begin : we_decode
    alloc_we = '0;
    if (disp_valid && free_found) begin
      alloc_we[free_idx] = 1'b1;
    end
  end

  assign rs_full = &busy;

  ////////////////////
  // Same-cycle wakeup
  ////////////////////

  // A result broadcast in the dispatch cycle would otherwise be missed
  always_comb begin : disp_wake
    hit1 = 1'b0;
    hit2 = 1'b0;
    for (int w = 0; w < num_wake; w++) begin
      if (wake_valid[w] && (wake_tag[w] == disp_src1)) begin
        hit1 = 1'b1;
      end
      if (wake_valid[w] && (wake_tag[w] == disp_src2)) begin
        hit2 = 1'b1;
      end
    end
  end

  assign alloc_rdy1 = disp_rdy1 | hit1;
  assign alloc_rdy2 = disp_rdy2 | hit2;

endmodule

`default_nettype wire

//--- design/div_rs_pkg.sv
`default_nettype none

package div_rs_pkg;

  ////////////////////
  // Divide operations
  ////////////////////

  localparam int op_w = 4;

  // Low three bits follow funct3 of the M extension and bit 3 marks the W forms
  typedef enum logic [op_w-1:0] {
    op_div   = 4'b0100,
    op_divu  = 4'b0101,
    op_rem   = 4'b0110,
    op_remu  = 4'b0111,
    op_divw  = 4'b1100,
    op_divuw = 4'b1101,
    op_remw  = 4'b1110,
    op_remuw = 4'b1111
  } div_op_e;

  ////////////////////
  // Entry indexing
  ////////////////////

  // Bits needed to name one of n entries
  function automatic int entry_idx_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

//--- design/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

  ////////////////////
  // Program counter
  ////////////////////

  localparam int pc_w = 32;

  typedef logic [pc_w-1:0] pc_t;  // Instruction address

  ////////////////////
  // Physical registers
  ////////////////////

  // Tag width sets the size of the physical register file
  localparam int tag_w = 8;

  typedef logic [tag_w-1:0] tag_t;  // Physical register tag

endpackage

`default_nettype wire
